//--- hw/stream_defines.svh
// Build-time constants shared by the tuser sideband wrapper.
// Include this header wherever a width, the FIFO depth or the
// packet mode default is needed. The types built on these widths
// live in stream_pkg.

`ifndef STREAM_DEFINES_SVH
`define STREAM_DEFINES_SVH

// Width of one data sample in bits
`define SB_DATA_WIDTH 16

// Width of one tuser sideband word in bits
`define SB_USER_WIDTH 8

// Log2 of the tuser FIFO depth, so 3 gives 8 entries
// The FIFO must cover the worst-case number of words in flight
`define SB_FIFO_DEPTH_LOG2 3

// Packet mode built by the top level
// 0 stores tuser per word, 1 keeps the first word's tuser for the packet,
// 2 keeps the last word's tuser for the packet
`define SB_PACKET_MODE 1

`endif

//--- hw/stream_pkg.sv
// Types for the tuser sideband wrapper and its processing block.
// Import with a wildcard in the module header of any file that
// uses a sample, user word, gain, stream beat or packet mode.

`include "stream_defines.svh"

package stream_pkg;

  // One data sample, one sideband word and the scaler gain
  typedef logic [`SB_DATA_WIDTH-1:0] sample_t;
  typedef logic [`SB_USER_WIDTH-1:0] user_t;
  typedef logic [`SB_DATA_WIDTH-1:0] gain_t;

  // Stream beat for blocks that carry no tuser
  typedef struct packed {
    sample_t data;
    logic    last;
  } beat_t;

  // Stream beat with the tuser sideband word alongside the sample
  typedef struct packed {
    sample_t data;
    user_t   user;
    logic    last;
  } user_beat_t;

  // How the wrapper stores tuser words in its FIFO
  typedef enum logic [1:0] {
    per_word   = 2'd0,
    first_word = 2'd1,
    last_word  = 2'd2
  } packet_mode_t;

endpackage

//--- hw/tuser_fifo.sv
// Synchronous first-word-fall-through FIFO for tuser sideband words.
// Both sides use valid/ready; a word moves on a rising edge where
// valid and ready are both high. The oldest word is shown on the read
// side whenever the FIFO holds anything, one cycle after its write.

`timescale 1ns/1ps

`include "stream_defines.svh"

module tuser_fifo import stream_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  user_t in_user,
  input  logic  in_valid,
  output logic  in_ready,
  output user_t out_user,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int DEPTH_LOG2 = `SB_FIFO_DEPTH_LOG2;
  localparam int DEPTH = 1 << DEPTH_LOG2;

  // Storage array, written at the write pointer and read at the read pointer
  user_t mem [DEPTH];

  // Pointers carry one extra bit so a full FIFO differs from an empty one
  logic [DEPTH_LOG2:0] wr_ptr;
  logic [DEPTH_LOG2:0] rd_ptr;

  logic empty;
  logic full;
  logic do_write;
  logic do_read;

  // Equal pointers mean empty
  assign empty = (wr_ptr == rd_ptr);

  // Same address but opposite wrap bit means every entry is taken
  assign full = (wr_ptr[DEPTH_LOG2-1:0] == rd_ptr[DEPTH_LOG2-1:0]) &&
                (wr_ptr[DEPTH_LOG2] != rd_ptr[DEPTH_LOG2]);

  assign in_ready  = !full;
  assign out_valid = !empty;

  assign do_write = in_valid && in_ready;
  assign do_read  = out_valid && out_ready;

  // The head of the queue falls through to the output
  assign out_user = mem[rd_ptr[DEPTH_LOG2-1:0]];

  // Data array has no reset, only the pointers do
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[wr_ptr[DEPTH_LOG2-1:0]] <= in_user;
    end
  end

  // Pointer update, reset leaves the FIFO empty
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      // A read and a write may happen on the same edge
      if (do_read) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

endmodule

//--- hw/sample_scaler.sv
// Two-stage valid/ready pipeline that multiplies each sample by a gain.
// The product keeps the low bits of the full product and tlast follows
// its sample. There is no tuser on either side, so the sideband wrapper
// carries that around this block. Up to two beats can be in flight.

`timescale 1ns/1ps

`include "stream_defines.svh"

module sample_scaler import stream_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  gain_t gain,
  input  beat_t in_beat,
  input  logic  in_valid,
  output logic  in_ready,
  output beat_t out_beat,
  output logic  out_valid,
  input  logic  out_ready
);

  // Stage one holds the input beat as accepted
  beat_t s1_beat;
  logic  s1_valid;

  // Product of the stage one sample and the gain, kept to the sample width
  sample_t product;

  logic s2_load;
  logic s1_load;

  // Stage two can take a new beat when it is empty or its beat leaves now
  assign s2_load = !out_valid || out_ready;

  // Stage one can take a new beat when it is empty or passes its beat on
  assign in_ready = !s1_valid || s2_load;
  assign s1_load  = in_valid && in_ready;

  // Gain is a static level and is sampled on every cycle
  assign product = s1_beat.data * gain;

  // Stage one payload, no reset needed
  always_ff @(posedge clk) begin
    if (s1_load) begin
      s1_beat <= in_beat;
    end
  end

  // Stage two payload, truncated product with tlast carried alongside
  always_ff @(posedge clk) begin
    if (s2_load && s1_valid) begin
      out_beat.data <= product;
      out_beat.last <= s1_beat.last;
    end
  end

  // Valid bits for both stages
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      // Stage one stays full while it waits for stage two
      if (in_ready) begin
        s1_valid <= in_valid;
      end
      // Stage two empties when its beat leaves and nothing replaces it
      if (s2_load) begin
        out_valid <= s1_valid;
      end
    end
  end

endmodule

//--- hw/sideband_tuser.sv
// Splits a stream with tuser into a data path through a processing
// block and a tuser path through a FIFO, then joins them at the output.
// PACKET_MODE picks which words put their tuser into the FIFO:
// every word, the first word of a packet or the last word of a packet.
// In the packet modes one FIFO word serves the whole packet and is
// released when the packet's last beat leaves.

`timescale 1ns/1ps

`include "stream_defines.svh"

module sideband_tuser import stream_pkg::*; #(
  parameter packet_mode_t PACKET_MODE = packet_mode_t'(`SB_PACKET_MODE)
) (
  input  logic       clk,
  input  logic       reset,
  input  user_beat_t s_beat,
  input  logic       s_valid,
  output logic       s_ready,
  output user_beat_t m_beat,
  output logic       m_valid,
  input  logic       m_ready,
  output beat_t      mod_in_beat,
  output logic       mod_in_valid,
  input  logic       mod_in_ready,
  input  beat_t      mod_out_beat,
  input  logic       mod_out_valid,
  output logic       mod_out_ready,
  output user_t      fifo_in_user,
  output logic       fifo_in_valid,
  input  logic       fifo_in_ready,
  input  user_t      fifo_out_user,
  input  logic       fifo_out_valid,
  output logic       fifo_out_ready
);

  // High while the next accepted input beat opens a packet
  logic first_beat;

  // Mode conditions for storing and releasing a FIFO word
  logic store_user;
  logic release_user;

  always_ff @(posedge clk) begin
    if (reset) begin
      first_beat <= 1'b1;
    end else if (s_valid && s_ready) begin
      // After a tlast the next beat starts a new packet
      first_beat <= s_beat.last;
    end
  end

  always_comb begin
    case (PACKET_MODE)
      first_word: begin
        store_user   = first_beat;
        release_user = mod_out_beat.last;
      end
      last_word: begin
        store_user   = s_beat.last;
        release_user = mod_out_beat.last;
      end
      default: begin
        store_user   = 1'b1;
        release_user = 1'b1;
      end
    endcase
  end

  // Input side, a beat is taken only when both paths can accept it
  assign s_ready          = fifo_in_ready && mod_in_ready;
  assign mod_in_beat.data = s_beat.data;
  assign mod_in_beat.last = s_beat.last;
  assign mod_in_valid     = s_valid && fifo_in_ready;
  assign fifo_in_user     = s_beat.user;
  assign fifo_in_valid    = s_valid && mod_in_ready && store_user;

  // Output side, data and tuser leave together
  assign m_beat.data    = mod_out_beat.data;
  assign m_beat.user    = fifo_out_user;
  assign m_beat.last    = mod_out_beat.last;
  assign m_valid        = mod_out_valid && fifo_out_valid;
  assign mod_out_ready  = m_ready && fifo_out_valid;
  assign fifo_out_ready = m_ready && mod_out_valid && release_user;

endmodule

//--- hw/sideband_top.sv
// Top level of the tuser sideband wrapper around the sample scaler.
// Input and output streams both carry tuser. The gain is a static
// level input. The packet mode comes from the defines header.

`timescale 1ns/1ps

`include "stream_defines.svh"

module sideband_top import stream_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  gain_t      gain,
  input  user_beat_t s_beat,
  input  logic       s_valid,
  output logic       s_ready,
  output user_beat_t m_beat,
  output logic       m_valid,
  input  logic       m_ready
);

  // Data path into and out of the scaler
  beat_t mod_in_beat;
  logic  mod_in_valid;
  logic  mod_in_ready;
  beat_t mod_out_beat;
  logic  mod_out_valid;
  logic  mod_out_ready;

  // Sideband path into and out of the FIFO
  user_t fifo_in_user;
  logic  fifo_in_valid;
  logic  fifo_in_ready;
  user_t fifo_out_user;
  logic  fifo_out_valid;
  logic  fifo_out_ready;

  sample_scaler u_scaler (
    .clk       (clk),
    .reset     (reset),
    .gain      (gain),
    .in_beat   (mod_in_beat),
    .in_valid  (mod_in_valid),
    .in_ready  (mod_in_ready),
    .out_beat  (mod_out_beat),
    .out_valid (mod_out_valid),
    .out_ready (mod_out_ready)
  );

  tuser_fifo u_fifo (
    .clk       (clk),
    .reset     (reset),
    .in_user   (fifo_in_user),
    .in_valid  (fifo_in_valid),
    .in_ready  (fifo_in_ready),
    .out_user  (fifo_out_user),
    .out_valid (fifo_out_valid),
    .out_ready (fifo_out_ready)
  );

  sideband_tuser #(
    .PACKET_MODE (packet_mode_t'(`SB_PACKET_MODE))
  ) u_sideband (
    .clk            (clk),
    .reset          (reset),
    .s_beat         (s_beat),
    .s_valid        (s_valid),
    .s_ready        (s_ready),
    .m_beat         (m_beat),
    .m_valid        (m_valid),
    .m_ready        (m_ready),
    .mod_in_beat    (mod_in_beat),
    .mod_in_valid   (mod_in_valid),
    .mod_in_ready   (mod_in_ready),
    .mod_out_beat   (mod_out_beat),
    .mod_out_valid  (mod_out_valid),
    .mod_out_ready  (mod_out_ready),
    .fifo_in_user   (fifo_in_user),
    .fifo_in_valid  (fifo_in_valid),
    .fifo_in_ready  (fifo_in_ready),
    .fifo_out_user  (fifo_out_user),
    .fifo_out_valid (fifo_out_valid),
    .fifo_out_ready (fifo_out_ready)
  );

endmodule

//--- sim/tb_clock.sv
// Clock and reset source for the sideband wrapper testbench.
// Makes a free-running 20 ns clock and holds the synchronous reset
// high for the first three rising edges.

`timescale 1ns/1ps

module tb_clock (
  output logic clk,
  output logic reset
);

  localparam int HALF_PERIOD = 10;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset drops just after an edge, like every other DUT input
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

//--- sim/sideband_tb.sv
// Random-stimulus testbench for the tuser sideband wrapper top level.
// Sends random packets through sideband_top, predicts every output beat
// with a queue model and compares sample, tlast and tuser one by one.
// A burst phase with the output held off checks back-pressure and drain.
// Inputs change 1 ns after a rising edge, handshakes are read at the
// falling edge where every signal has settled.

`timescale 1ns/1ps

`include "stream_defines.svh"

module sideband_tb import stream_pkg::*; ();

  localparam int NUM_PACKETS    = 200;
  localparam int MAX_LEN        = 6;
  localparam int BURST_PACKETS  = 20;
  localparam int HOLD_CYCLES    = 40;
  localparam int IDLE_CYCLES    = 10;
  localparam int TIMEOUT_CYCLES = NUM_PACKETS * MAX_LEN * 10;
  localparam int DRIVE_DELAY    = 1;

  // How m_ready is driven in a given phase
  localparam int READY_RANDOM = 0;
  localparam int READY_LOW    = 1;
  localparam int READY_HIGH   = 2;

  logic       clk;
  logic       reset;
  gain_t      gain;
  user_beat_t s_beat;
  logic       s_valid;
  logic       s_ready;
  user_beat_t m_beat;
  logic       m_valid;
  logic       m_ready;

  // Words still to send, and the beats expected at the output in order
  user_beat_t stim_q[$];
  user_beat_t model_q[$];

  int    seed;
  int    send_idx;
  int    in_count;
  int    out_count;
  int    cycle_count;
  int    valid_pct;
  int    ready_mode;
  logic  took;
  logic  in_first;
  user_t pkt_user;
  logic  saw_stall;
  string test_name;

  tb_clock u_clock (
    .clk   (clk),
    .reset (reset)
  );

  sideband_top dut (
    .clk     (clk),
    .reset   (reset),
    .gain    (gain),
    .s_beat  (s_beat),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .m_beat  (m_beat),
    .m_valid (m_valid),
    .m_ready (m_ready)
  );

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Run stopped after a failure");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERR %s expected 0x%0h actual 0x%0h", name, expected, actual);
      $display("** FAIL **");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  // Appends packets of random length with a random sample and user per word
  task automatic build_packets(input int count, input int max_len);
    user_beat_t  beat;
    logic [31:0] rnd;
    int          len;
    for (int p = 0; p < count; p++) begin
      len = 1 + rand_below(max_len);
      for (int w = 0; w < len; w++) begin
        rnd        = $random(seed);
        beat.data  = rnd[15:0];
        rnd        = $random(seed);
        beat.user  = rnd[7:0];
        beat.last  = (w == len - 1);
        stim_q.push_back(beat);
      end
    end
  endtask

  // A raised s_valid stays with its word until that word is taken
  task automatic drive_inputs();
    if (took || !s_valid) begin
      s_valid = 1'b0;
      if (send_idx < stim_q.size() && rand_below(100) < valid_pct) begin
        s_beat  = stim_q[send_idx];
        s_valid = 1'b1;
      end
    end
    took = 1'b0;
    case (ready_mode)
      READY_LOW:  m_ready = 1'b0;
      READY_HIGH: m_ready = 1'b1;
      // Low about 30% of the time
      default:    m_ready = (rand_below(100) >= 30);
    endcase
  endtask

  // Records the transfers that the coming rising edge will make
  task automatic observe_outputs();
    user_beat_t  expected;
    logic [31:0] product;
    if (s_valid && s_ready) begin
      // First word mode, every beat carries its packet's opening tuser
      if (in_first) begin
        pkt_user = s_beat.user;
      end
      in_first      = s_beat.last;
      product       = {16'd0, s_beat.data} * {16'd0, gain};
      expected.data = product[15:0];
      expected.user = pkt_user;
      expected.last = s_beat.last;
      model_q.push_back(expected);
      send_idx++;
      in_count++;
      took = 1'b1;
    end
    if (s_valid && !s_ready) begin
      saw_stall = 1'b1;
    end
    if (m_valid && m_ready) begin
      if (model_q.size() == 0) begin
        report_failure("Output beat arrived with no input beat left to match it");
      end else begin
        expected = model_q.pop_front();
        check({test_name, " sample"}, {16'd0, expected.data}, {16'd0, m_beat.data});
        check({test_name, " tlast"}, {31'd0, expected.last}, {31'd0, m_beat.last});
        check({test_name, " tuser"}, {24'd0, expected.user}, {24'd0, m_beat.user});
        out_count++;
      end
    end
  endtask

  task automatic run_cycle();
    @(posedge clk);
    #DRIVE_DELAY;
    drive_inputs();
    @(negedge clk);
    observe_outputs();
  endtask

  // Ends a run that stops making progress
  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      report_failure($sformatf("Run hung, no end after %0d cycles", TIMEOUT_CYCLES));
    end
  end

  initial begin
    logic [31:0] rnd;
    s_beat      = '0;
    s_valid     = 1'b0;
    m_ready     = 1'b0;
    gain        = '0;
    seed        = 32'hc96e;
    send_idx    = 0;
    in_count    = 0;
    out_count   = 0;
    cycle_count = 0;
    valid_pct   = 0;
    ready_mode  = READY_RANDOM;
    took        = 1'b0;
    in_first    = 1'b1;
    pkt_user    = '0;
    saw_stall   = 1'b0;
    test_name   = "reset";

    rnd  = $random(seed);
    gain = rnd[15:0];

    // The model follows the first word rule, so the build must match it
    check("packet mode", 32'd1, `SB_PACKET_MODE);

    // Nothing leaves the DUT during reset or in the first cycle after it
    @(negedge clk);
    while (reset) begin
      check("reset m_valid", 32'd0, {31'd0, m_valid});
      @(negedge clk);
    end
    check("post-reset m_valid", 32'd0, {31'd0, m_valid});

    // Random packets with random gaps and random back-pressure
    test_name  = "random";
    valid_pct  = 70;
    ready_mode = READY_RANDOM;
    build_packets(NUM_PACKETS, MAX_LEN);
    while (send_idx < stim_q.size()) begin
      run_cycle();
    end

    // One-word packets against a stalled output until the scaler fills
    test_name  = "burst";
    build_packets(BURST_PACKETS, 1);
    valid_pct  = 100;
    ready_mode = READY_LOW;
    saw_stall  = 1'b0;
    repeat (HOLD_CYCLES) begin
      run_cycle();
    end
    check("burst s_ready fell", 32'd1, {31'd0, saw_stall});
    ready_mode = READY_HIGH;
    while (send_idx < stim_q.size()) begin
      run_cycle();
    end

    // Let every beat still in flight come out
    test_name  = "drain";
    valid_pct  = 0;
    ready_mode = READY_RANDOM;
    while (out_count < in_count) begin
      run_cycle();
    end

    // With every input matched the output must stay quiet, so no beat comes twice
    test_name  = "idle";
    ready_mode = READY_HIGH;
    repeat (IDLE_CYCLES) begin
      run_cycle();
      check("idle m_valid", 32'd0, {31'd0, m_valid});
    end

    $display("** PASS **");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+hw
hw/stream_pkg.sv
hw/tuser_fifo.sv
hw/sample_scaler.sv
hw/sideband_tuser.sv
hw/sideband_top.sv
sim/tb_clock.sv
sim/sideband_tb.sv

//--- Makefile
# Verilator build and run of the tuser sideband wrapper testbench
# Any variable below can be overridden on the command line

VERILATOR  ?= verilator
TOP        ?= sideband_tb
RTL_TOP    ?= sideband_top
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_TEXT  ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_TEXT)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
